/* hw/cam_pkg.sv */
`default_nettype none

package cam_pkg;

    // Table geometry
    localparam int KEY_W   = 8;               // Stored and search key width
    localparam int VAL_W   = 8;               // Associated value width
    localparam int ENTRIES = 16;              // Number of table entries
    localparam int IDX_W   = $clog2(ENTRIES); // Entry index width

    // Key of one entry or of a search
    typedef logic [KEY_W-1:0] key_t;

    // Value stored beside each key
    typedef logic [VAL_W-1:0] val_t;

    typedef logic [IDX_W-1:0] idx_t;       // Entry number

    // One compare result per entry with bit i for entry i
    typedef logic [ENTRIES-1:0] match_vec_t;

endpackage

`default_nettype wire

/* hw/entry_write_if.sv */
`default_nettype none

// One table update from the host to both storage blocks
interface entry_write_if import cam_pkg::*; ();

    logic wr;      // Single-cycle update strobe
    logic inval;   // Drops the entry instead of loading it when wr is high
    idx_t addr;    // Entry being updated
    key_t key;     // New key that an invalidate ignores
    val_t value;   // New value that an invalidate ignores

    // Key storage needs the key but not the value
    modport key_side (
        input wr,
        input inval,
        input addr,
        input key
    );

    // Value storage needs the value but not the key
    modport val_side (
        input wr,
        input inval,
        input addr,
        input value
    );

endinterface

`default_nettype wire

/* hw/match_if.sv */
`default_nettype none

// Registered search result one stage after the lookup edge
interface match_if import cam_pkg::*; ();

    logic valid;   // One pulse per lookup
    logic hit;     // At least one valid entry matched
    logic multi;   // Two or more entries matched
    idx_t index;   // Lowest matching entry or zero on a miss

    // Producer side in the encoder
    modport enc_side (
        output valid,
        output hit,
        output multi,
        output index
    );

    // Consumer side in the value stage
    modport res_side (
        input valid,
        input hit,
        input multi,
        input index
    );

endinterface

`default_nettype wire

/* hw/cam_array.sv */
`default_nettype none

module cam_array import cam_pkg::*; (
    input  wire                clk,
    input  wire                rst_n,
    entry_write_if.key_side    upd,         // Host update port
    input  wire key_t          lookup_key,  // Search key
    output match_vec_t         match_lines  // One line per entry
);

    key_t       key_mem [ENTRIES];  // Stored keys
    logic [ENTRIES-1:0] valid_q;    // Entry holds a live key

    logic load_en;   // Normal write
    logic drop_en;   // Invalidate

    assign load_en = upd.wr && !upd.inval;
    assign drop_en = upd.wr &&  upd.inval;

    // Valid bits set by writes and cleared by invalidates
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (load_en) begin
            valid_q[upd.addr] <= 1'b1;   // Entry becomes live
        end else if (drop_en) begin
            valid_q[upd.addr] <= 1'b0;   // Key stays but the entry is dead
        end
    end

    // Key words change only on a real write
    always_ff @(posedge clk) begin
        if (load_en) begin
            key_mem[upd.addr] <= upd.key;
        end
    end

    // Parallel compare of the search key against every entry
    // Table state seen here is the one before the current edge
    // so a write at the same edge as a lookup is not visible yet
    always_comb begin
        for (int i = 0; i < ENTRIES; i++) begin
            match_lines[i] = valid_q[i] && (key_mem[i] == lookup_key); // Gate by valid
        end
    end

endmodule

`default_nettype wire

/* hw/match_encoder.sv */
`default_nettype none

module match_encoder import cam_pkg::*; (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             lookup,       // Search strobe for each lookup
    input  wire match_vec_t match_lines,  // Raw compare results
    match_if.enc_side       res           // Registered result
);

    logic any_hit;    // Any line set
    logic many_hit;   // Two or more lines set
    idx_t low_idx;    // Lowest set line

    // Lowest set bit wins and no set bit gives zero
    function automatic idx_t lowest_set(input match_vec_t lines);
        idx_t idx;
        idx = '0;
        // Walk downward so the last assignment is the lowest index
        for (int i = ENTRIES - 1; i >= 0; i--) begin
            if (lines[i]) begin
                idx = idx_t'(i);
            end
        end
        return idx;
    endfunction

    assign any_hit = |match_lines;

    // Clearing the lowest set bit leaves something only if a second bit was set
    assign many_hit = |(match_lines & (match_lines - match_vec_t'(1)));

    assign low_idx = lowest_set(match_lines);

    // Result register one stage behind the lookup strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res.valid <= 1'b0;
            res.hit   <= 1'b0;
            res.multi <= 1'b0;
            res.index <= '0;
        end else if (lookup) begin
            res.valid <= 1'b1;
            res.hit   <= any_hit;
            res.multi <= many_hit;
            res.index <= low_idx;   // Already zero on a miss
        end else begin
            // Fields go back to zero on an idle cycle
            res.valid <= 1'b0;
            res.hit   <= 1'b0;
            res.multi <= 1'b0;
            res.index <= '0;
        end
    end

endmodule

`default_nettype wire

/* hw/result_ram.sv */
`default_nettype none

module result_ram import cam_pkg::*; (
    input  wire             clk,
    input  wire             rst_n,
    entry_write_if.val_side upd,        // Host update port
    match_if.res_side       res,        // Result from the encoder
    output logic            out_valid,
    output logic            out_hit,
    output logic            out_multi,
    output idx_t            out_index,
    output val_t            out_value
);

    val_t value_mem [ENTRIES];   // Associated values

    // Invalidate leaves the value word alone
    always_ff @(posedge clk) begin
        if (upd.wr && !upd.inval) begin
            value_mem[upd.addr] <= upd.value;
        end
    end

    // Output stage two cycles after the lookup edge
    // Value read sees the array before this edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_hit   <= 1'b0;
            out_multi <= 1'b0;
            out_index <= '0;
            out_value <= '0;
        end else if (res.valid) begin
            out_valid <= 1'b1;
            out_hit   <= res.hit;
            out_multi <= res.multi;
            out_index <= res.index;
            out_value <= res.hit ? value_mem[res.index] : '0; // Miss reads as zero
        end else begin
            // Everything holds zero without a result
            out_valid <= 1'b0;
            out_hit   <= 1'b0;
            out_multi <= 1'b0;
            out_index <= '0;
            out_value <= '0;
        end
    end

endmodule

`default_nettype wire

/* hw/cam_lookup_top.sv */
`default_nettype none

module cam_lookup_top import cam_pkg::*; (
    input  wire       clk,
    input  wire       rst_n,

    // Host update
    input  wire       wr,          // Update strobe
    input  wire       inval,       // Update is an invalidate
    input  wire idx_t addr,        // Entry to update
    input  wire key_t key,         // Key to store
    input  wire val_t value,       // Value to store

    // Search
    input  wire       lookup,      // Search strobe
    input  wire key_t lookup_key,  // Key to search for

    // Result two cycles after the search edge
    output logic      out_valid,
    output logic      out_hit,
    output logic      out_multi,
    output idx_t      out_index,
    output val_t      out_value
);

    entry_write_if upd_if ();      // Update bus to both stores
    match_if       match_bus ();   // Encoder to value stage

    match_vec_t match_lines;       // Combinational compare results

    // Update bus comes straight from the pins
    assign upd_if.wr    = wr;
    assign upd_if.inval = inval;
    assign upd_if.addr  = addr;
    assign upd_if.key   = key;
    assign upd_if.value = value;

    // Key store and compare
    cam_array u_cam_array (
        .clk         (clk),
        .rst_n       (rst_n),
        .upd         (upd_if.key_side),
        .lookup_key  (lookup_key),
        .match_lines (match_lines)
    );

    // First pipeline stage
    match_encoder u_match_encoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .lookup      (lookup),
        .match_lines (match_lines),
        .res         (match_bus.enc_side)
    );

    // Value store and second stage
    result_ram u_result_ram (
        .clk       (clk),
        .rst_n     (rst_n),
        .upd       (upd_if.val_side),
        .res       (match_bus.res_side),
        .out_valid (out_valid),
        .out_hit   (out_hit),
        .out_multi (out_multi),
        .out_index (out_index),
        .out_value (out_value)
    );

endmodule

`default_nettype wire

/* verif/cam_lookup_tb.sv */
`default_nettype none

module cam_lookup_tb import cam_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int    CLK_PERIOD = 40;
    localparam int    MAX_ROWS   = 256;
    localparam int    NCOL       = 13;   // Columns per trace row
    localparam string TRACE_FILE = "verif/cam_lookup_trace.txt";

    // Trace column positions
    localparam int C_TEST  = 0;
    localparam int C_WR    = 1;
    localparam int C_INVAL = 2;
    localparam int C_ADDR  = 3;
    localparam int C_KEY   = 4;
    localparam int C_VALUE = 5;
    localparam int C_LOOK  = 6;
    localparam int C_LKEY  = 7;
    localparam int C_VALID = 8;   // Expected outputs from here on
    localparam int C_HIT   = 9;
    localparam int C_MULTI = 10;
    localparam int C_INDEX = 11;
    localparam int C_OVAL  = 12;

    logic clk;
    logic rst_n;
    logic wr;
    logic inval;
    idx_t addr;
    key_t key;
    val_t value;
    logic lookup;
    key_t lookup_key;
    logic out_valid;
    logic out_hit;
    logic out_multi;
    idx_t out_index;
    val_t out_value;

    logic [7:0] trace_mem [MAX_ROWS][NCOL];   // One row per clock cycle
    int n_rows;
    int check_cnt;     // All compares
    int fail_cnt;      // All mismatches
    int test_checks;   // Compares in the running test
    int test_errs;     // Mismatches in the running test
    bit rows_loaded = 1'b0;

    cam_lookup_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr         (wr),
        .inval      (inval),
        .addr       (addr),
        .key        (key),
        .value      (value),
        .lookup     (lookup),
        .lookup_key (lookup_key),
        .out_valid  (out_valid),
        .out_hit    (out_hit),
        .out_multi  (out_multi),
        .out_index  (out_index),
        .out_value  (out_value)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;   // 40 ns period

    // Only data rows parse to NCOL fields so comment and blank lines drop out
    task automatic load_trace(output int count);
        int    fd;
        int    got;
        string line;
        int    f [NCOL];
        count = 0;
        fd = $fopen(TRACE_FILE, "r");
        if (fd != 0) begin
            while (!$feof(fd) && count < MAX_ROWS) begin
                line = "";
                void'($fgets(line, fd));
                got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                              f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                              f[7], f[8], f[9], f[10], f[11], f[12]);
                if (got == NCOL) begin
                    for (int c = 0; c < NCOL; c++) begin
                        trace_mem[count][c] = f[c][7:0];
                    end
                    count++;
                end
            end
            $fclose(fd);
        end
    endtask

    // Inputs of one row that the DUT samples at the next rising edge
    task automatic apply_row(input int r);
        wr         <= trace_mem[r][C_WR][0];
        inval      <= trace_mem[r][C_INVAL][0];
        addr       <= idx_t'(trace_mem[r][C_ADDR]);
        key        <= trace_mem[r][C_KEY];
        value      <= trace_mem[r][C_VALUE];
        lookup     <= trace_mem[r][C_LOOK][0];
        lookup_key <= trace_mem[r][C_LKEY];
    endtask

    task automatic compare_field(input int row, input string name,
                                 input logic [7:0] actual, input logic [7:0] expected);
        check_cnt++;
        test_checks++;
        assert (actual === expected) else begin
            $display("Fail %s row %0d: expected 0x%h, got 0x%h", name, row, expected, actual);
            fail_cnt++;
            test_errs++;
        end
    endtask

    task automatic check_row(input int r);
        compare_field(r, "out_valid", 8'(out_valid), trace_mem[r][C_VALID]);
        compare_field(r, "out_hit",   8'(out_hit),   trace_mem[r][C_HIT]);
        compare_field(r, "out_multi", 8'(out_multi), trace_mem[r][C_MULTI]);
        compare_field(r, "out_index", 8'(out_index), trace_mem[r][C_INDEX]);
        compare_field(r, "out_value", out_value,     trace_mem[r][C_OVAL]);
    endtask

    task automatic report_test(input logic [7:0] test_num);
        $display("Test %0d done: %0d checks, %0d errors", test_num, test_checks, test_errs);
        test_checks = 0;
        test_errs   = 0;
    endtask

    initial begin
        rst_n       = 1'b0;
        wr          = 1'b0;
        inval       = 1'b0;
        addr        = '0;
        key         = '0;
        value       = '0;
        lookup      = 1'b0;
        lookup_key  = '0;
        check_cnt   = 0;
        fail_cnt    = 0;
        test_checks = 0;
        test_errs   = 0;
        load_trace(n_rows);
        if (n_rows == 0) begin
            $display("Trace file missing or empty, nothing to replay");
            $display("TB FAILED");
            $finish;
        end else begin
            rows_loaded = 1'b1;
            repeat (3) @(posedge clk);   // Reset held for three cycles
            rst_n <= 1'b1;
            for (int r = 0; r < n_rows; r++) begin
                @(posedge clk);
                apply_row(r);
                @(negedge clk);          // Outputs settled mid-cycle
                if (r > 0 && trace_mem[r][C_TEST] != trace_mem[r-1][C_TEST]) begin
                    report_test(trace_mem[r-1][C_TEST]);
                end
                check_row(r);
            end
            report_test(trace_mem[n_rows-1][C_TEST]);
            $display("Summary: %0d checks, %0d passed, %0d failed",
                     check_cnt, check_cnt - fail_cnt, fail_cnt);
            if (fail_cnt == 0) begin
                $display("TB PASSED");
            end else begin
                $display("TB FAILED");
            end
            $finish;
        end
    end

    // Watchdog budget of one period per row plus margin for reset
    initial begin
        wait (rows_loaded);
        #((n_rows + 10) * CLK_PERIOD);
        $display("Timeout: trace replay did not finish within %0d cycles", n_rows + 10);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/cam_lookup_trace.txt */
# test wr inval addr key value lookup lookup_key | exp valid hit multi index value
# All hex, one row per cycle, a lookup's result is expected two rows later
1 0 0 0 00 00 1 5a  0 0 0 0 00
1 0 0 0 00 00 1 00  0 0 0 0 00
1 0 0 0 00 00 0 00  1 0 0 0 00
1 0 0 0 00 00 0 00  1 0 0 0 00
1 0 0 0 00 00 0 00  0 0 0 0 00
2 1 0 5 a7 3c 0 00  0 0 0 0 00
2 0 0 0 00 00 1 a7  0 0 0 0 00
2 0 0 0 00 00 0 00  0 0 0 0 00
2 0 0 0 00 00 0 00  1 1 0 5 3c
2 1 0 e 11 99 1 a7  0 0 0 0 00
2 0 0 0 00 00 1 11  0 0 0 0 00
2 0 0 0 00 00 0 00  1 1 0 5 3c
2 0 0 0 00 00 0 00  1 1 0 e 99
3 1 0 3 42 33 0 00  0 0 0 0 00
3 1 0 9 42 90 0 00  0 0 0 0 00
3 1 0 c 42 c0 1 42  0 0 0 0 00
3 1 1 3 00 00 0 00  0 0 0 0 00
3 0 0 0 00 00 1 42  1 1 1 3 33
3 0 0 0 00 00 0 00  0 0 0 0 00
3 0 0 0 00 00 0 00  1 1 1 9 90
4 1 1 9 00 00 0 00  0 0 0 0 00
4 1 0 e 77 55 1 42  0 0 0 0 00
4 0 0 0 00 00 1 11  0 0 0 0 00
4 0 0 0 00 00 1 77  1 1 0 c c0
4 0 0 0 00 00 1 a7  1 0 0 0 00
4 0 0 0 00 00 0 00  1 1 0 e 55
4 0 0 0 00 00 0 00  1 1 0 5 3c
4 0 0 0 00 00 0 00  0 0 0 0 00
5 1 0 0 be ef 1 be  0 0 0 0 00
5 0 0 0 00 00 1 be  0 0 0 0 00
5 0 0 0 00 00 1 42  1 0 0 0 00
5 0 0 0 00 00 1 a7  1 1 0 0 ef
5 0 0 0 00 00 0 00  1 1 0 c c0
5 0 0 0 00 00 0 00  1 1 0 5 3c
5 0 0 0 00 00 0 00  0 0 0 0 00

/* vlog.f */
hw/cam_pkg.sv
hw/entry_write_if.sv
hw/match_if.sv
hw/cam_array.sv
hw/match_encoder.sv
hw/result_ram.sv
hw/cam_lookup_top.sv
verif/cam_lookup_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run from the project root so the trace path resolves
verilator --binary --timing --assert --top-module cam_lookup_tb -f vlog.f -o cam_lookup_sim \
    && ./obj_dir/cam_lookup_sim > sim.log \
    ; cat sim.log \
    && grep -q "TB PASSED" sim.log \
    || { echo "run_sim: simulation did not pass, see sim.log"; exit 1; }
